// ==== include/rob_cfg.svh ====
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// depth must stay a power of two
`define ROB_DEPTH       16
`define ROB_ADDR_LEN    4

// port counts
`define DISPATCH_WIDTH  2
`define RETIRE_WIDTH    2
`define WB_PORTS        3
`define RD_PORTS        4

// datapath widths
`define DATA_WIDTH      32
`define AREG_WIDTH      5
`define PC_WIDTH        32

`endif

// ==== rtl/rob_pkg.sv ====
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [`ROB_ADDR_LEN-1:0] rob_addr_t;

    // index plus wrap bit
    typedef logic [`ROB_ADDR_LEN:0] rob_ptr_t;

    typedef enum logic [1:0] {
        ST_FREE,
        ST_WAIT,
        ST_DONE
    } entry_state_e;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_ADEL,
        EXC_ADES,
        EXC_RI,
        EXC_OV,
        EXC_SYS
    } exc_cause_e;

    typedef struct packed {
        entry_state_e                 state;
        logic                         has_dst;
        logic [`AREG_WIDTH-1:0]       areg;
        logic [`PC_WIDTH-1:0]         pc;
        logic [`DATA_WIDTH-1:0]       data;
        exc_cause_e                   cause;
    } rob_entry_t;

    typedef struct packed {
        logic                         valid;
        logic                         has_dst;
        logic [`AREG_WIDTH-1:0]       areg;
        logic [`PC_WIDTH-1:0]         pc;
    } dispatch_req_t;

    typedef struct packed {
        logic                         valid;
        rob_addr_t                    tag;
        logic [`DATA_WIDTH-1:0]       data;
        exc_cause_e                   cause;
    } wb_req_t;

    typedef struct packed {
        logic                         ready;
        logic [`DATA_WIDTH-1:0]       data;
    } operand_t;

    typedef struct packed {
        logic                         valid;
        logic                         has_dst;
        logic [`AREG_WIDTH-1:0]       areg;
        logic [`DATA_WIDTH-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic                         valid;
        rob_addr_t                    tag;
        logic [`PC_WIDTH-1:0]         pc;
        exc_cause_e                   cause;
    } exc_report_t;

endpackage

`default_nettype wire

// ==== rtl/rob_alloc.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rob_cfg.svh"

module rob_alloc (
    input  logic                   clk,
    input  logic                   resetn,
    input  rob_pkg::dispatch_req_t dispatch_req [`DISPATCH_WIDTH],
    input  rob_pkg::rob_ptr_t      head_ptr,
    input  rob_pkg::rob_ptr_t      head_next,
    input  logic                   flush,
    output logic                   dispatch_ready,
    output rob_pkg::rob_addr_t     dispatch_tag [`DISPATCH_WIDTH],
    output rob_pkg::rob_ptr_t      tail_ptr,
    output logic                   alloc_we [`DISPATCH_WIDTH],
    output rob_pkg::rob_addr_t     alloc_addr [`DISPATCH_WIDTH]
);
    import rob_pkg::*;

    rob_ptr_t free_cnt;
    rob_ptr_t alloc_cnt;

    // wrap bit makes full and empty distinguishable
    assign free_cnt = rob_ptr_t'(`ROB_DEPTH) - rob_ptr_t'(tail_ptr - head_ptr);

    assign dispatch_ready = (free_cnt >= rob_ptr_t'(`DISPATCH_WIDTH)) && !flush;

    // valid slots are packed, so tags follow tail in slot order
    always_comb begin
        rob_ptr_t cnt;
        cnt = '0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            dispatch_tag[k] = rob_addr_t'(tail_ptr + cnt);
            alloc_we[k]     = dispatch_ready && dispatch_req[k].valid;
            alloc_addr[k]   = dispatch_tag[k];
            if (dispatch_req[k].valid) begin
                cnt = cnt + 1'b1;
            end
        end
        alloc_cnt = dispatch_ready ? cnt : '0;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tail_ptr <= '0;
        end else if (flush) begin
            // everything younger than the excepting entry is dropped
            tail_ptr <= head_next;
        end else begin
            tail_ptr <= tail_ptr + alloc_cnt;
        end
    end

    a_free_bound: assert property (@(posedge clk) disable iff (!resetn)
        free_cnt <= rob_ptr_t'(`ROB_DEPTH))
        else $error("rob_alloc: free count above depth");

    // tail only moves on an accepted group or a flush
    a_no_alloc_when_busy: assert property (@(posedge clk) disable iff (!resetn)
        (!dispatch_ready && !flush) |=> tail_ptr == $past(tail_ptr))
        else $error("rob_alloc: allocation while dispatch_ready low");

endmodule

`default_nettype wire

// ==== rtl/rob_table.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rob_cfg.svh"

module rob_table (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   alloc_we [`DISPATCH_WIDTH],
    input  rob_pkg::rob_addr_t     alloc_addr [`DISPATCH_WIDTH],
    input  rob_pkg::dispatch_req_t dispatch_req [`DISPATCH_WIDTH],
    input  rob_pkg::wb_req_t       wb [`WB_PORTS],
    input  rob_pkg::rob_ptr_t      head_ptr,
    input  logic                   flush,
    input  rob_pkg::rob_addr_t     rd_tag [`RD_PORTS],
    output rob_pkg::operand_t      rd_operand [`RD_PORTS],
    output rob_pkg::rob_entry_t    head_window [`RETIRE_WIDTH]
);
    import rob_pkg::*;

    rob_entry_t table_q    [`ROB_DEPTH];
    rob_entry_t table_wb   [`ROB_DEPTH];
    rob_entry_t table_next [`ROB_DEPTH];
    rob_addr_t  head_addr;

    assign head_addr = head_ptr[`ROB_ADDR_LEN-1:0];

    // writeback merge feeds the operand bypass
    always_comb begin
        table_wb = table_q;
        for (int p = 0; p < `WB_PORTS; p++) begin
            if (wb[p].valid) begin
                table_wb[wb[p].tag].state = ST_DONE;
                table_wb[wb[p].tag].data  = wb[p].data;
                table_wb[wb[p].tag].cause = wb[p].cause;
            end
        end
    end

    always_comb begin
        table_next = table_wb;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            if (alloc_we[k]) begin
                table_next[alloc_addr[k]].state   = ST_WAIT;
                table_next[alloc_addr[k]].has_dst = dispatch_req[k].has_dst;
                table_next[alloc_addr[k]].areg    = dispatch_req[k].areg;
                table_next[alloc_addr[k]].pc      = dispatch_req[k].pc;
                table_next[alloc_addr[k]].data    = '0;
                table_next[alloc_addr[k]].cause   = EXC_NONE;
            end
        end
        // flush wins over everything
        if (flush) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                table_next[i].state = ST_FREE;
            end
        end
    end

    // entries start free
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                table_q[i].state <= ST_FREE;
            end
        end else begin
            table_q <= table_next;
        end
    end

    for (genvar p = 0; p < `RD_PORTS; p++) begin : g_rd
        assign rd_operand[p].ready = (table_wb[rd_tag[p]].state == ST_DONE);
        assign rd_operand[p].data  = table_wb[rd_tag[p]].data;
    end

    // registered view of the oldest entries for retire
    for (genvar i = 0; i < `RETIRE_WIDTH; i++) begin : g_head
        rob_addr_t win_addr;
        assign win_addr       = head_addr + rob_addr_t'(i);
        assign head_window[i] = table_q[win_addr];
    end

    for (genvar p = 0; p < `WB_PORTS; p++) begin : g_wb_chk
        a_wb_to_wait: assert property (@(posedge clk) disable iff (!resetn)
            wb[p].valid |-> table_q[wb[p].tag].state == ST_WAIT)
            else $error("rob_table: writeback on port %0d to tag %0h not waiting",
                        p, wb[p].tag);
    end

endmodule

`default_nettype wire

// ==== rtl/rob_retire.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rob_cfg.svh"

module rob_retire (
    input  logic                clk,
    input  logic                resetn,
    input  rob_pkg::rob_entry_t head_window [`RETIRE_WIDTH],
    input  rob_pkg::rob_ptr_t   tail_ptr,
    output rob_pkg::rob_ptr_t   head_ptr,
    output rob_pkg::rob_ptr_t   head_next,
    output rob_pkg::retire_t    retire [`RETIRE_WIDTH],
    output rob_pkg::exc_report_t exc,
    output logic                flush
);
    import rob_pkg::*;

    rob_ptr_t occupancy;
    rob_ptr_t ret_cnt;

    assign occupancy = tail_ptr - head_ptr;
    assign head_next = head_ptr + 1'b1;

    // longest in-order run of clean completed entries
    always_comb begin
        logic stop;
        stop    = 1'b0;
        ret_cnt = '0;
        for (int i = 0; i < `RETIRE_WIDTH; i++) begin
            retire[i] = '0;
            if (!stop && rob_ptr_t'(i) < occupancy &&
                head_window[i].state == ST_DONE &&
                head_window[i].cause == EXC_NONE) begin
                retire[i].valid   = 1'b1;
                retire[i].has_dst = head_window[i].has_dst;
                retire[i].areg    = head_window[i].areg;
                retire[i].data    = head_window[i].data;
                ret_cnt           = ret_cnt + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

    // excepting head blocks retire through the cause check above
    assign exc.valid = (occupancy != '0) &&
                       (head_window[0].state == ST_DONE) &&
                       (head_window[0].cause != EXC_NONE);
    assign exc.tag   = head_ptr[`ROB_ADDR_LEN-1:0];
    assign exc.pc    = head_window[0].pc;
    assign exc.cause = head_window[0].cause;

    assign flush = exc.valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            head_ptr <= '0;
        end else if (flush) begin
            // skip the excepting entry
            head_ptr <= head_next;
        end else begin
            head_ptr <= head_ptr + ret_cnt;
        end
    end

    // head never overtakes the tail
    a_ret_bound: assert property (@(posedge clk) disable iff (!resetn)
        occupancy <= rob_ptr_t'(`ROB_DEPTH))
        else $error("rob_retire: retired more entries than occupied");

endmodule

`default_nettype wire

// ==== rtl/rob_top.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rob_cfg.svh"

module rob_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  rob_pkg::dispatch_req_t dispatch_req [`DISPATCH_WIDTH],
    output logic                   dispatch_ready,
    output rob_pkg::rob_addr_t     dispatch_tag [`DISPATCH_WIDTH],
    input  rob_pkg::wb_req_t       wb [`WB_PORTS],
    input  rob_pkg::rob_addr_t     rd_tag [`RD_PORTS],
    output rob_pkg::operand_t      rd_operand [`RD_PORTS],
    output rob_pkg::retire_t       retire [`RETIRE_WIDTH],
    output rob_pkg::exc_report_t   exc
);
    import rob_pkg::*;

    rob_ptr_t   head_ptr;
    rob_ptr_t   head_next;
    rob_ptr_t   tail_ptr;
    logic       flush;
    logic       alloc_we    [`DISPATCH_WIDTH];
    rob_addr_t  alloc_addr  [`DISPATCH_WIDTH];
    rob_entry_t head_window [`RETIRE_WIDTH];

    rob_alloc u_alloc (
        .clk            (clk),
        .resetn         (resetn),
        .dispatch_req   (dispatch_req),
        .head_ptr       (head_ptr),
        .head_next      (head_next),
        .flush          (flush),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .tail_ptr       (tail_ptr),
        .alloc_we       (alloc_we),
        .alloc_addr     (alloc_addr)
    );

    rob_table u_table (
        .clk          (clk),
        .resetn       (resetn),
        .alloc_we     (alloc_we),
        .alloc_addr   (alloc_addr),
        .dispatch_req (dispatch_req),
        .wb           (wb),
        .head_ptr     (head_ptr),
        .flush        (flush),
        .rd_tag       (rd_tag),
        .rd_operand   (rd_operand),
        .head_window  (head_window)
    );

    rob_retire u_retire (
        .clk         (clk),
        .resetn      (resetn),
        .head_window (head_window),
        .tail_ptr    (tail_ptr),
        .head_ptr    (head_ptr),
        .head_next   (head_next),
        .retire      (retire),
        .exc         (exc),
        .flush       (flush)
    );

endmodule

`default_nettype wire

// ==== test/tb_rob.sv ====
`default_nettype none
`timescale 1ns/100ps

`include "rob_cfg.svh"

module tb_rob;
    import rob_pkg::*;

    typedef retire_t [`RETIRE_WIDTH-1:0] ret_group_t;

    typedef struct packed {
        rob_addr_t                tag;
        logic                     has_dst;
        logic [`AREG_WIDTH-1:0]   areg;
        logic [`PC_WIDTH-1:0]     pc;
        logic [`DATA_WIDTH-1:0]   data;
        exc_cause_e               cause;
        logic                     done;
    } model_entry_t;

    logic          clk;
    logic          resetn;
    dispatch_req_t dispatch_req [`DISPATCH_WIDTH];
    logic          dispatch_ready;
    rob_addr_t     dispatch_tag [`DISPATCH_WIDTH];
    wb_req_t       wb [`WB_PORTS];
    rob_addr_t     rd_tag [`RD_PORTS];
    operand_t      rd_operand [`RD_PORTS];
    retire_t       retire [`RETIRE_WIDTH];
    exc_report_t   exc;

    // program-order model with the oldest at index 0
    model_entry_t  model_q [$];
    rob_addr_t     model_head;
    logic          grp_accepted;
    logic [31:0]   lfsr_state;
    int            checks;
    int            errors;
    int            retired_total;
    int            exc_seen;

    rob_top u_dut (
        .clk            (clk),
        .resetn         (resetn),
        .dispatch_req   (dispatch_req),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .wb             (wb),
        .rd_tag         (rd_tag),
        .rd_operand     (rd_operand),
        .retire         (retire),
        .exc            (exc)
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int find_tag(input rob_addr_t tag);
        foreach (model_q[i]) begin
            if (model_q[i].tag == tag) begin
                return i;
            end
        end
        return -1;
    endfunction

    // in-order prefix of clean completed entries
    function automatic ret_group_t expected_retire();
        ret_group_t grp;
        int i;
        grp = '0;
        i = 0;
        while (i < `RETIRE_WIDTH && i < model_q.size() && model_q[i].done &&
               model_q[i].cause == EXC_NONE) begin
            grp[i].valid   = 1'b1;
            grp[i].has_dst = model_q[i].has_dst;
            grp[i].areg    = model_q[i].areg;
            grp[i].data    = model_q[i].data;
            i++;
        end
        return grp;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // one model cycle against the DUT before the rising edge
    task automatic check_cycle();
        ret_group_t  exp_ret;
        exc_report_t exp_exc;
        operand_t    exp_op;
        logic        exp_ready;
        rob_addr_t   tail_before;
        int          n_ret;
        int          n_valid;
        int          idx;

        tail_before = rob_addr_t'(model_head + model_q.size());
        exp_ret = expected_retire();
        n_ret = 0;
        for (int k = 0; k < `RETIRE_WIDTH; k++) begin
            check_value($sformatf("retire[%0d]", k), retire[k], exp_ret[k]);
            n_ret += exp_ret[k].valid;
            retired_total += retire[k].valid;
        end

        exp_exc = '0;
        if (model_q.size() != 0 && model_q[0].done && model_q[0].cause != EXC_NONE) begin
            exp_exc.valid = 1'b1;
            exp_exc.tag   = model_q[0].tag;
            exp_exc.pc    = model_q[0].pc;
            exp_exc.cause = model_q[0].cause;
            check_value("exc", exc, exp_exc);
        end else begin
            check_value("exc.valid", exc.valid, 1'b0);
        end
        exc_seen += exc.valid;

        exp_ready = (`ROB_DEPTH - model_q.size() >= `DISPATCH_WIDTH) && !exp_exc.valid;
        check_value("dispatch_ready", dispatch_ready, exp_ready);

        // only live tags have a defined operand
        for (int p = 0; p < `RD_PORTS; p++) begin
            idx = find_tag(rd_tag[p]);
            if (idx >= 0) begin
                exp_op = '0;
                if (model_q[idx].done) begin
                    exp_op.ready = 1'b1;
                    exp_op.data  = model_q[idx].data;
                end
                for (int w = 0; w < `WB_PORTS; w++) begin
                    if (wb[w].valid && wb[w].tag == rd_tag[p]) begin
                        exp_op.ready = 1'b1;
                        exp_op.data  = wb[w].data;
                    end
                end
                if (exp_op.ready) begin
                    check_value($sformatf("rd_operand[%0d]", p), rd_operand[p], exp_op);
                end else begin
                    check_value($sformatf("rd_operand[%0d].ready", p),
                                rd_operand[p].ready, 1'b0);
                end
            end
        end

        if (exp_exc.valid) begin
            model_q.delete();
            model_head = model_head + 1'b1;
        end else begin
            for (int k = 0; k < n_ret; k++) begin
                void'(model_q.pop_front());
            end
            model_head = rob_addr_t'(model_head + n_ret);
            for (int w = 0; w < `WB_PORTS; w++) begin
                idx = wb[w].valid ? find_tag(wb[w].tag) : -1;
                if (idx >= 0) begin
                    model_q[idx].done  = 1'b1;
                    model_q[idx].data  = wb[w].data;
                    model_q[idx].cause = wb[w].cause;
                end
            end
        end

        n_valid = 0;
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            if (dispatch_req[k].valid) begin
                check_value($sformatf("dispatch_tag[%0d]", k), dispatch_tag[k],
                            rob_addr_t'(tail_before + n_valid));
                if (exp_ready) begin
                    model_q.push_back({rob_addr_t'(tail_before + n_valid),
                                       dispatch_req[k].has_dst, dispatch_req[k].areg,
                                       dispatch_req[k].pc, `DATA_WIDTH'(0), EXC_NONE, 1'b0});
                end
                n_valid++;
            end
        end
        grp_accepted = exp_ready && (n_valid != 0);
    endtask

    // a nanosecond after the inputs change
    always begin
        @(negedge clk);
        #1;
        if (resetn) begin
            check_cycle();
        end
    end

    task automatic clear_inputs();
        for (int k = 0; k < `DISPATCH_WIDTH; k++) begin
            dispatch_req[k] = '0;
        end
        for (int w = 0; w < `WB_PORTS; w++) begin
            wb[w] = '0;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        clear_inputs();
        for (int p = 0; p < `RD_PORTS; p++) begin
            rd_tag[p] = (model_q.size() != 0) ? model_q[take_bits(4) % model_q.size()].tag
                                              : rob_addr_t'(take_bits(`ROB_ADDR_LEN));
        end
    endtask

    task automatic present_group(input int n);
        for (int k = 0; k < n; k++) begin
            dispatch_req[k].valid   = 1'b1;
            dispatch_req[k].has_dst = 1'(take_bits(1));
            dispatch_req[k].areg    = `AREG_WIDTH'(take_bits(`AREG_WIDTH));
            dispatch_req[k].pc      = take_bits(30) << 2;
        end
    endtask

    task automatic dispatch_group(input int n);
        int tries;
        tries = 0;
        next_cycle();
        present_group(n);
        next_cycle();
        while (!grp_accepted) begin
            if (tries > 40) abort_on_timeout("a dispatch group was never accepted");
            tries++;
            present_group(n);
            next_cycle();
        end
    endtask

    task automatic drive_wb(input int port, input rob_addr_t tag, input exc_cause_e cause);
        wb[port].valid = 1'b1;
        wb[port].tag   = tag;
        wb[port].data  = take_bits(32);
        wb[port].cause = cause;
    endtask

    // up to WB_PORTS pending tags in random order
    task automatic writeback_random();
        int pend [$];
        int n;
        int pick;
        next_cycle();
        foreach (model_q[i]) begin
            if (!model_q[i].done) pend.push_back(i);
        end
        n = take_bits(2) % (`WB_PORTS + 1);
        for (int w = 0; w < n && pend.size() != 0; w++) begin
            pick = take_bits(4) % pend.size();
            drive_wb(w, model_q[pend[pick]].tag, EXC_NONE);
            pend.delete(pick);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (model_q.size() != 0) begin
            if (cycles > 200) abort_on_timeout("the buffer did not drain");
            writeback_random();
            cycles++;
        end
        next_cycle();
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-14s %s", name, (errors == err_before) ? "ok" : "failed");
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        check_value("dispatch_ready", dispatch_ready, 1'b1);
        for (int k = 0; k < `RETIRE_WIDTH; k++) begin
            check_value($sformatf("retire[%0d].valid", k), retire[k].valid, 1'b0);
        end
        check_value("exc.valid", exc.valid, 1'b0);
        // tags 0 and 1 come from the model tail
        dispatch_group(2);
        drain();
        report_test("reset", e);
    endtask

    task automatic test_random_order();
        int e;
        e = errors;
        repeat (4) dispatch_group(2);
        drain();
        report_test("random_order", e);
    endtask

    task automatic test_retire_stop();
        int e;
        int r0;
        e = errors;
        dispatch_group(2);
        dispatch_group(2);
        r0 = retired_total;
        next_cycle();
        drive_wb(0, model_q[1].tag, EXC_NONE);
        drive_wb(1, model_q[2].tag, EXC_NONE);
        drive_wb(2, model_q[3].tag, EXC_NONE);
        repeat (3) next_cycle();
        check_value("retired while head pending", retired_total - r0, 0);
        drive_wb(0, model_q[0].tag, EXC_NONE);
        repeat (3) next_cycle();
        check_value("retired after head done", retired_total - r0, 4);
        drain();
        report_test("retire_stop", e);
    endtask

    task automatic test_full();
        int e;
        int cycles;
        e = errors;
        cycles = 0;
        next_cycle();
        while (dispatch_ready) begin
            if (cycles > `ROB_DEPTH) abort_on_timeout("dispatch_ready never fell");
            present_group(`DISPATCH_WIDTH);
            next_cycle();
            cycles++;
        end
        // refused groups
        repeat (3) begin
            present_group(`DISPATCH_WIDTH);
            next_cycle();
        end
        cycles = 0;
        while (!dispatch_ready) begin
            if (cycles > 40) abort_on_timeout("dispatch_ready did not rise again");
            writeback_random();
            cycles++;
        end
        drain();
        report_test("full", e);
    endtask

    task automatic test_operand();
        int e;
        rob_addr_t t0;
        rob_addr_t t1;
        e = errors;
        dispatch_group(2);
        t0 = model_q[0].tag;
        t1 = model_q[1].tag;
        next_cycle();
        drive_wb(0, t0, EXC_NONE);
        rd_tag[0] = t0;
        rd_tag[1] = t1;
        next_cycle();
        rd_tag[0] = t0;
        rd_tag[1] = t1;
        drain();
        report_test("operand", e);
    endtask

    task automatic test_exception();
        int e;
        int x0;
        int r0;
        e = errors;
        dispatch_group(2);
        dispatch_group(2);
        x0 = exc_seen;
        r0 = retired_total;
        next_cycle();
        drive_wb(0, model_q[0].tag, EXC_NONE);
        drive_wb(1, model_q[1].tag, EXC_OV);
        drive_wb(2, model_q[2].tag, EXC_NONE);
        next_cycle();
        drive_wb(0, model_q[3].tag, EXC_NONE);
        // the flush cycle refuses this group
        next_cycle();
        present_group(2);
        repeat (2) next_cycle();
        check_value("exc reports", exc_seen - x0, 1);
        check_value("retired around exc", retired_total - r0, 1);
        dispatch_group(2);
        drain();
        report_test("exception", e);
    endtask

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        lfsr_state = 32'ha3b7_9e9a;
        model_head = '0;
        grp_accepted = 1'b0;
        checks = 0;
        errors = 0;
        retired_total = 0;
        exc_seen = 0;
        clear_inputs();
        for (int p = 0; p < `RD_PORTS; p++) begin
            rd_tag[p] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        test_reset();
        test_random_order();
        test_retire_stop();
        test_full();
        test_operand();
        test_exception();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_table.sv
rtl/rob_retire.sv
rtl/rob_top.sv
test/tb_rob.sv
